// File: project.f
+incdir+common
common/rv_pkg.sv
regfile/rv_register_file.sv
hdl/rv_decoder.sv
hdl/rv_alu.sv
hdl/rv_exec_top.sv
dv/rv_exec_sva.sv
dv/rv_exec_tb.sv

// File: Bender.yml
package:
  name: rv_exec

sources:
  - include_dirs:
      - common
    files:
      - common/rv_pkg.sv
      - regfile/rv_register_file.sv
      - hdl/rv_decoder.sv
      - hdl/rv_alu.sv
      - hdl/rv_exec_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - dv/rv_exec_sva.sv
      - dv/rv_exec_tb.sv

// File: dv/rv_exec_tb.sv
// Checks rv_exec_top with directed and seeded random instructions; results must come back in order
`timescale 1ns/100ps
`include "rv_defs.svh"

module rv_exec_tb;

  import rv_pkg::*;

  // Cycles a result or a drain may take before the run counts as hung
  localparam int WAIT_LIMIT = 20;

  // funct3 per ALU operation, in enum order
  localparam logic [2:0] F3 [8] = '{3'b000, 3'b000, 3'b111, 3'b110,
                                    3'b100, 3'b010, 3'b001, 3'b101};

  logic                clk;
  logic                rst_n;
  logic                instr_valid_i;
  rv_instr_u           instr_i;
  rv_wb_t              ld_wb_i;
  rv_res_t             res_o;

  // Shadow registers, entry 0 never written
  logic [`RV_XLEN-1:0] shadow [`RV_NUM_WORDS] = '{default: '0};
  rv_res_t             exp_q [$];
  rv_res_t             expected;
  integer              seed;
  int                  errors;
  int                  test_err0;
  int                  tests_failed;
  int                  wait_cnt;
  string               test_name;

  rv_exec_top u_rv_exec_top (
    .clk           (clk),
    .rst_n         (rst_n),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .ld_wb_i       (ld_wb_i),
    .res_o         (res_o)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  // --------------------
  // Reference model
  // --------------------

  function automatic logic [`RV_XLEN-1:0] alu_ref(rv_alu_op_e op, logic [`RV_XLEN-1:0] a,
                                                  logic [`RV_XLEN-1:0] b);
    case (op)
      ADD:     return a + b;
      SUB:     return a - b;
      AND:     return a & b;
      OR:      return a | b;
      XOR:     return a ^ b;
      // Signed compare
      SLT:     return ($signed(a) < $signed(b)) ? 1 : 0;
      SLL:     return a << b[4:0];
      default: return a >> b[4:0];
    endcase
  endfunction

  // RV32I OP and OP-IMM encodings
  function automatic logic [31:0] encode(rv_alu_op_e op, bit imm_form, logic [4:0] rd,
                                         logic [4:0] rs1, logic [4:0] rs2, logic [11:0] imm);
    logic [6:0] f7;
    f7 = (op == SUB) ? 7'b0100000 : 7'b0000000;
    if (imm_form) begin
      return {imm, rs1, F3[op], rd, 7'b0010011};
    end
    return {f7, rs2, rs1, F3[op], rd, 7'b0110011};
  endfunction

  // One stimulus cycle, a load lands after any ALU write to the same register
  task automatic drive(logic [31:0] ins, rv_wb_t ld, rv_res_t exp);
    @(negedge clk);
    instr_valid_i = exp.valid;
    instr_i       = ins;
    ld_wb_i       = ld;
    if (exp.valid) begin
      exp_q.push_back(exp);
    end
    if (ld.we && ld.addr != '0) begin
      shadow[ld.addr] = ld.data;
    end
  endtask

  task automatic exec(rv_alu_op_e op, bit imm_form, logic [4:0] rd, logic [4:0] rs1,
                      logic [4:0] rs2, logic [11:0] imm, rv_wb_t ld = '0);
    rv_res_t             exp;
    logic [`RV_XLEN-1:0] b;
    b   = imm_form ? {{(`RV_XLEN-12){imm[11]}}, imm} : shadow[rs2];
    exp = '{valid: 1'b1, illegal: 1'b0, rd: rd, data: alu_ref(op, shadow[rs1], b)};
    if (rd != '0) begin
      shadow[rd] = exp.data;
    end
    drive(encode(op, imm_form, rd, rs1, rs2, imm), ld, exp);
  endtask

  // Illegal word is flagged with zero data and changes no register
  task automatic exec_illegal(logic [31:0] ins);
    rv_res_t exp;
    exp = '{valid: 1'b1, illegal: 1'b1, rd: ins[11:7], data: '0};
    drive(ins, '0, exp);
  endtask

  task automatic begin_test(string name);
    test_name = name;
    test_err0 = errors;
  endtask

  // Idle one cycle, drain outstanding results, report the test
  task automatic end_test();
    int n;
    drive('0, '0, '0);
    n = 0;
    while (exp_q.size() != 0 && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    assert (exp_q.size() == 0) else begin
      $display("%s: results still outstanding after %0d cycles", test_name, n);
      errors++;
    end
    if (errors != test_err0) begin
      tests_failed++;
    end
    $display("%s: %0d errors", test_name, errors - test_err0);
  endtask

  // --------------------
  // Comparison
  // --------------------

  // Sampled mid-cycle, away from the edge that updates res_o
  always @(negedge clk) begin
    if (exp_q.size() == 0) begin
      wait_cnt = 0;
      assert (!res_o.valid) else begin
        $display("%s: result valid with no instruction outstanding", test_name);
        errors++;
      end
    end else if (res_o.valid) begin
      wait_cnt = 0;
      expected = exp_q.pop_front();
      assert (res_o == expected) else begin
        $display("Mismatch %s: expected %h actual %h", test_name, expected, res_o);
        errors++;
      end
    end else begin
      wait_cnt++;
      if (wait_cnt > WAIT_LIMIT) begin
        $display("%s: no result from the DUT within %0d cycles", test_name, WAIT_LIMIT);
        $display("tests failed");
        $finish;
      end
    end
  end

  initial begin : stimulus
    logic [31:0] r;
    logic [4:0]  rd;
    logic [4:0]  prev_rd;
    logic [4:0]  prev2_rd;
    rv_wb_t      ld;
    rv_alu_op_e  imm_ops [4];

    imm_ops       = '{ADD, AND, OR, XOR};
    seed          = 32'hd5ea_0439;
    errors        = 0;
    tests_failed  = 0;
    wait_cnt      = 0;
    test_name     = "reset";
    rst_n         = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    ld_wb_i       = '0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // All registers zero, ADDI to x0 discarded
    begin_test("reset_and_x0");
    for (int k = 0; k < `RV_NUM_WORDS; k++) begin
      exec(OR, 1'b0, 5'd0, 5'(k), 5'(k), '0);
    end
    exec(ADD, 1'b1, 5'd0, 5'd0, 5'd0, 12'h5a3);
    exec(ADD, 1'b0, 5'd5, 5'd0, 5'd0, '0);
    end_test();

    begin_test("immediate_ops");
    for (int k = 0; k < 40; k++) begin
      r = $random(seed);
      exec(imm_ops[r[1:0]], 1'b1, r[6:2], r[11:7], 5'd0, r[23:12]);
    end
    end_test();

    // rs1 is always the previous rd, rs2 often the one before
    begin_test("reg_ops_back_to_back");
    prev_rd  = 5'd1;
    prev2_rd = 5'd2;
    for (int k = 0; k < 60; k++) begin
      r  = $random(seed);
      rd = (r[4:0] == '0) ? 5'd31 : r[4:0];
      exec(rv_alu_op_e'(r[7:5]), 1'b0, rd, prev_rd, r[8] ? prev2_rd : r[13:9], '0);
      prev2_rd = prev_rd;
      prev_rd  = rd;
    end
    end_test();

    // Load and ALU hit x9 in one cycle
    begin_test("write_port_priority");
    ld.we   = 1'b1;
    ld.addr = 5'd9;
    ld.data = $random(seed);
    exec(XOR, 1'b0, 5'd9, 5'd3, 5'd4, '0, ld);
    exec(ADD, 1'b0, 5'd10, 5'd9, 5'd0, '0);
    end_test();

    // First load aimed at x0
    begin_test("load_return");
    for (int k = 0; k < 12; k++) begin
      r       = $random(seed);
      ld.addr = (k == 0) ? 5'd0 : r[4:0];
      ld.data = $random(seed);
      drive('0, ld, '0);
      exec(ADD, 1'b0, 5'd0, ld.addr, 5'd0, '0);
    end
    end_test();

    // Unknown opcode, M-extension funct7, SRAI; x7 and x8 keep their values
    begin_test("illegal_encodings");
    exec(ADD, 1'b1, 5'd7, 5'd0, 5'd0, 12'h3c1);
    exec(ADD, 1'b1, 5'd8, 5'd0, 5'd0, 12'h7f0);
    exec_illegal({7'b0000000, 5'd2, 5'd1, 3'b000, 5'd7, 7'b1011011});
    exec_illegal({7'b0000001, 5'd2, 5'd1, 3'b000, 5'd8, 7'b0110011});
    exec_illegal({7'b0100000, 5'd3, 5'd1, 3'b101, 5'd7, 7'b0010011});
    exec(ADD, 1'b0, 5'd0, 5'd7, 5'd0, '0);
    exec(ADD, 1'b0, 5'd0, 5'd8, 5'd0, '0);
    end_test();

    $display("6 tests, %0d failed, %0d errors", tests_failed, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: dv/rv_exec_sva.sv
// Bound to rv_exec_top; register file ports are watched through the top level port wires
`timescale 1ns/100ps
`include "rv_defs.svh"

module rv_exec_sva (
  input logic                  clk,
  input logic                  rst_n,
  input logic [`RV_ADDR_W-1:0] raddr0_i,
  input logic [`RV_ADDR_W-1:0] raddr1_i,
  input logic [`RV_XLEN-1:0]   rdata0_i,
  input logic [`RV_XLEN-1:0]   rdata1_i,
  input logic                  instr_valid_i,
  input logic                  illegal_i,
  input logic                  alu_we_i,
  input logic                  res_valid_i
);

  // x0 reads zero on both read ports
  a_x0_port0: assert property (@(posedge clk) disable iff (!rst_n)
    raddr0_i == '0 |-> rdata0_i == '0) else $error("x0 read nonzero on port 0");
  a_x0_port1: assert property (@(posedge clk) disable iff (!rst_n)
    raddr1_i == '0 |-> rdata1_i == '0) else $error("x0 read nonzero on port 1");

  // Back-to-back results only from back-to-back strobes
  a_valid_run: assert property (@(posedge clk) disable iff (!rst_n)
    res_valid_i && $past(res_valid_i) |-> $past(instr_valid_i) && $past(instr_valid_i, 2))
    else $error("result valid held without matching strobes");

  // ALU write port stays idle for illegal words
  a_illegal_no_write: assert property (@(posedge clk) disable iff (!rst_n)
    illegal_i |-> !alu_we_i) else $error("illegal instruction wrote the register file");

endmodule

bind rv_exec_top rv_exec_sva u_exec_sva (
  .clk           (clk),
  .rst_n         (rst_n),
  .raddr0_i      (raddr[0]),
  .raddr1_i      (raddr[1]),
  .rdata0_i      (rdata[0]),
  .rdata1_i      (rdata[1]),
  .instr_valid_i (instr_valid_i),
  .illegal_i     (ctrl.illegal),
  .alu_we_i      (wr[0].we),
  .res_valid_i   (res_o.valid)
);

// File: hdl/rv_exec_top.sv
// Execute slice top; one instruction per cycle, no stall, load writes beat ALU writes to one rd
`timescale 1ns/100ps
`include "rv_defs.svh"

module rv_exec_top (
  input  logic              clk,
  input  logic              rst_n,

  // Instruction strobe and word
  input  logic              instr_valid_i,
  input  rv_pkg::rv_instr_u instr_i,

  // Load return, strobed by its we field
  input  rv_pkg::rv_wb_t    ld_wb_i,

  // Registered result
  output rv_pkg::rv_res_t   res_o
);

  import rv_pkg::*;

  rv_ctrl_t            ctrl;
  rv_wb_t              alu_wb;

  // Register file port bundles
  logic [`RV_ADDR_W-1:0] raddr [`RV_NUM_RPORTS];
  logic [`RV_XLEN-1:0]   rdata [`RV_NUM_RPORTS];
  rv_wb_t                wr    [`RV_NUM_WPORTS];

  // --------------------
  // Port mapping
  // --------------------

  // rs1 on read port 0, rs2 on read port 1
  assign raddr[0] = ctrl.rs1;
  assign raddr[1] = ctrl.rs2;

  // ALU on write port 0, load return on the higher-priority port 1
  assign wr[0] = alu_wb;
  assign wr[1] = ld_wb_i;

  // --------------------
  // Instances
  // --------------------

  rv_decoder u_decoder (
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .ctrl_o        (ctrl)
  );

  rv_register_file u_regfile (
    .clk     (clk),
    .rst_n   (rst_n),
    .raddr_i (raddr),
    .rdata_o (rdata),
    .wr_i    (wr)
  );

  rv_alu u_alu (
    .clk           (clk),
    .rst_n         (rst_n),
    .ctrl_i        (ctrl),
    .instr_valid_i (instr_valid_i),
    .op_a_i        (rdata[0]),
    .op_b_i        (rdata[1]),
    .wb_o          (alu_wb),
    .res_o         (res_o)
  );

endmodule

// File: hdl/rv_alu.sv
// Single-cycle ALU; SLT is signed, shifts use operand b bits 4:0, no arithmetic right shift
`timescale 1ns/100ps
`include "rv_defs.svh"

module rv_alu (
  input  logic                clk,
  input  logic                rst_n,
  input  rv_pkg::rv_ctrl_t    ctrl_i,
  input  logic                instr_valid_i,
  input  logic [`RV_XLEN-1:0] op_a_i,
  input  logic [`RV_XLEN-1:0] op_b_i,
  output rv_pkg::rv_wb_t      wb_o,
  output rv_pkg::rv_res_t     res_o
);

  import rv_pkg::*;

  logic [`RV_XLEN-1:0] op_b;
  logic [`RV_XLEN-1:0] result;
  rv_res_t             res_q;

  // --------------------
  // Compute
  // --------------------

  // Immediate forms take the sign-extended imm as operand b
  assign op_b = ctrl_i.use_imm ? ctrl_i.imm : op_b_i;

  always_comb begin
    case (ctrl_i.op)
      ADD:     result = op_a_i + op_b;
      SUB:     result = op_a_i - op_b;
      AND:     result = op_a_i & op_b;
      OR:      result = op_a_i | op_b;
      XOR:     result = op_a_i ^ op_b;
      SLT:     result = {{(`RV_XLEN-1){1'b0}}, $signed(op_a_i) < $signed(op_b)};
      SLL:     result = op_a_i << op_b[4:0];
      SRL:     result = op_a_i >> op_b[4:0];
      default: result = '0;
    endcase
  end

  // Port 0 write lands at the same edge as the visible result
  assign wb_o = '{we: ctrl_i.we, addr: ctrl_i.rd, data: result};

  // --------------------
  // Result register
  // --------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      res_q <= '0;
    end else begin
      // One-cycle valid pulse per instruction
      res_q.valid <= instr_valid_i;
      if (instr_valid_i) begin
        res_q.illegal <= ctrl_i.illegal;
        res_q.rd      <= ctrl_i.rd;
        // Illegal instructions report zero data
        res_q.data    <= ctrl_i.illegal ? '0 : result;
      end
    end
  end

  assign res_o = res_q;

endmodule

// File: hdl/rv_decoder.sv
// RV32I ALU subset decoder; no SRA/SRAI, SLTU or SLTIU, anything else is flagged illegal
`timescale 1ns/100ps
`include "rv_defs.svh"

module rv_decoder (
  input  logic              instr_valid_i,
  input  rv_pkg::rv_instr_u instr_i,
  output rv_pkg::rv_ctrl_t  ctrl_o
);

  import rv_pkg::*;

  // Major opcodes handled here
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

  // funct7 of SUB, the only alternate R-type encoding accepted
  localparam logic [6:0] F7_ALT     = 7'b0100000;

  rv_ctrl_t ctrl;

  always_comb begin
    // Defaults follow the R-type view
    ctrl.rs1     = instr_i.r.rs1;
    ctrl.rs2     = instr_i.r.rs2;
    ctrl.rd      = instr_i.r.rd;
    ctrl.op      = ADD;
    ctrl.use_imm = 1'b0;
    ctrl.imm     = {{(`RV_XLEN-12){instr_i.i.imm12[11]}}, instr_i.i.imm12};
    ctrl.illegal = 1'b0;

    case (instr_i.r.opcode)
      OPC_OP: begin
        case (instr_i.r.funct3)
          3'b000:  ctrl.op = (instr_i.r.funct7 == F7_ALT) ? SUB : ADD;
          3'b001:  ctrl.op = SLL;
          3'b010:  ctrl.op = SLT;
          3'b100:  ctrl.op = XOR;
          3'b101:  ctrl.op = SRL;
          3'b110:  ctrl.op = OR;
          3'b111:  ctrl.op = AND;
          default: ctrl.illegal = 1'b1;
        endcase
        // funct7 must be zero, except SUB
        if (instr_i.r.funct7 != '0 &&
            !(instr_i.r.funct7 == F7_ALT && instr_i.r.funct3 == 3'b000)) begin
          ctrl.illegal = 1'b1;
        end
      end

      OPC_OP_IMM: begin
        // Immediate replaces rs2, read port 1 parked on x0
        ctrl.rs2     = '0;
        ctrl.use_imm = 1'b1;
        case (instr_i.i.funct3)
          3'b000:  ctrl.op = ADD;
          3'b010:  ctrl.op = SLT;
          3'b100:  ctrl.op = XOR;
          3'b110:  ctrl.op = OR;
          3'b111:  ctrl.op = AND;
          3'b001:  ctrl.op = SLL;
          3'b101:  ctrl.op = SRL;
          default: ctrl.illegal = 1'b1;
        endcase
        // Shift immediates carry funct7 in the upper bits
        if ((instr_i.i.funct3 == 3'b001 || instr_i.i.funct3 == 3'b101) &&
            instr_i.i.imm12[11:5] != '0) begin
          ctrl.illegal = 1'b1;
        end
      end

      default: ctrl.illegal = 1'b1;
    endcase

    // Writes only for valid, legal instructions with rd other than x0
    ctrl.we = instr_valid_i && !ctrl.illegal && (ctrl.rd != '0);
  end

  assign ctrl_o = ctrl;

endmodule

// File: regfile/rv_register_file.sv
// Flip-flop register file, x0 hardwired to zero, reads combinational, highest write port wins
`timescale 1ns/100ps
`include "rv_defs.svh"

module rv_register_file (
  input  logic                  clk,
  input  logic                  rst_n,

  // Read ports
  input  logic [`RV_ADDR_W-1:0] raddr_i [`RV_NUM_RPORTS],
  output logic [`RV_XLEN-1:0]   rdata_o [`RV_NUM_RPORTS],

  // Write ports, index 0 lowest priority
  input  rv_pkg::rv_wb_t        wr_i    [`RV_NUM_WPORTS]
);

  // Storage for x1..x31 only, x0 has no flops
  logic [`RV_XLEN-1:0]        mem    [1:`RV_NUM_WORDS-1];

  // Per port, per register write enables
  logic [`RV_NUM_WORDS-1:1]   we_dec [`RV_NUM_WPORTS];

  // --------------------
  // Read
  // --------------------

  for (genvar p = 0; p < `RV_NUM_RPORTS; p++) begin : gen_rd
    // Address 0 bypasses the array and returns zero
    assign rdata_o[p] = (raddr_i[p] == '0) ? '0 : mem[raddr_i[p]];
  end

  // --------------------
  // Write decode
  // --------------------

  for (genvar p = 0; p < `RV_NUM_WPORTS; p++) begin : gen_wdec
    for (genvar w = 1; w < `RV_NUM_WORDS; w++) begin : gen_word
      // One-hot enable per port, x0 never decoded
      assign we_dec[p][w] = wr_i[p].we && (wr_i[p].addr == `RV_ADDR_W'(w));
    end
  end

  // --------------------
  // Write
  // --------------------

  for (genvar w = 1; w < `RV_NUM_WORDS; w++) begin : gen_regs
    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        mem[w] <= '0;
      end else begin
        // Later ports overwrite earlier ones, so the load port beats the ALU
        for (int p = 0; p < `RV_NUM_WPORTS; p++) begin
          if (we_dec[p][w]) begin
            mem[w] <= wr_i[p].data;
          end
        end
      end
    end
  end

endmodule

// File: common/rv_pkg.sv
// Shared types for the execute slice; field widths follow rv_defs.svh and RV32I encodings
`include "rv_defs.svh"

package rv_pkg;

  // --------------------
  // Instruction formats
  // --------------------

  // R-type view, register to register
  typedef struct packed {
    logic [6:0]            funct7;
    logic [`RV_ADDR_W-1:0] rs2;
    logic [`RV_ADDR_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [`RV_ADDR_W-1:0] rd;
    logic [6:0]            opcode;
  } rv_r_instr_t;

  // I-type view, 12-bit immediate replaces funct7 and rs2
  typedef struct packed {
    logic [11:0]           imm12;
    logic [`RV_ADDR_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [`RV_ADDR_W-1:0] rd;
    logic [6:0]            opcode;
  } rv_i_instr_t;

  // One instruction word, read through either view
  typedef union packed {
    rv_r_instr_t r;
    rv_i_instr_t i;
  } rv_instr_u;

  // --------------------
  // Control and results
  // --------------------

  typedef enum logic [2:0] {
    ADD, SUB, AND, OR, XOR, SLT, SLL, SRL
  } rv_alu_op_e;

  // Decoder output, imm already sign-extended
  typedef struct packed {
    logic [`RV_ADDR_W-1:0] rs1;
    logic [`RV_ADDR_W-1:0] rs2;
    logic [`RV_ADDR_W-1:0] rd;
    rv_alu_op_e            op;
    logic                  use_imm;
    logic [`RV_XLEN-1:0]   imm;
    logic                  we;
    logic                  illegal;
  } rv_ctrl_t;

  // One register file write
  typedef struct packed {
    logic                  we;
    logic [`RV_ADDR_W-1:0] addr;
    logic [`RV_XLEN-1:0]   data;
  } rv_wb_t;

  // Visible result, one per instruction
  typedef struct packed {
    logic                  valid;
    logic                  illegal;
    logic [`RV_ADDR_W-1:0] rd;
    logic [`RV_XLEN-1:0]   data;
  } rv_res_t;

endpackage

// File: common/rv_defs.svh
// Sizes for the execute slice; RV32I only, so data width and word count must stay at 32
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// --------------------
// Datapath
// --------------------

// Width of one register and of the ALU datapath
`define RV_XLEN 32

// --------------------
// Register file
// --------------------

// Number of architectural registers, x0 included
`define RV_NUM_WORDS 32

// Register address width, log2 of the word count
`define RV_ADDR_W 5

// Combinational read ports, rs1 on port 0 and rs2 on port 1
`define RV_NUM_RPORTS 2

// Write ports, port 0 is the ALU and port 1 the load return
`define RV_NUM_WPORTS 2

`endif
